// ==== hdl/merge_config.svh ====
// merge subsystem configuration
// word width, FIFO depth and channel count shared by both packages
`ifndef MERGE_CONFIG_SVH
`define MERGE_CONFIG_SVH

// width of one data word in bits
`define MERGE_DWIDTH 16

// FIFO address width
// 4 address bits give a depth of 16 words
`define MERGE_AWIDTH 4

// number of merged input channels
`define MERGE_NCHAN 2

`endif

// ==== hdl/fifo_pkg.sv ====
// FIFO types
// data word, RAM address and occupancy count used by the FIFO and its users

`include "merge_config.svh"

package fifo_pkg;

   // one data word as it travels through the subsystem
   typedef logic [`MERGE_DWIDTH-1:0] data_t;

   // RAM address inside one FIFO
   typedef logic [`MERGE_AWIDTH-1:0] addr_t;

   // occupancy in words
   // one bit wider than the address so a full FIFO can be counted
   // top bit set means full
   typedef logic [`MERGE_AWIDTH:0] dcount_t;

endpackage: fifo_pkg

// ==== hdl/merge_pkg.sv ====
// merger types
// source channel tag and round-robin priority state

`include "merge_config.svh"

package merge_pkg;

   // channel a word came from
   // travels with each output word as its tag
   typedef enum logic [$clog2(`MERGE_NCHAN)-1:0] {
      CHAN_A,
      CHAN_B
   } chan_t;

   // which channel wins when both FIFOs hold data
   typedef enum logic {
      PRIO_A,
      PRIO_B
   } arb_state_t;

endpackage: merge_pkg

// ==== hdl/fifo_rd_if.sv ====
// FIFO read-side bundle
// look-ahead head, status flags and read strobe between one FIFO and the merger

`timescale 1ns/1ps

interface fifo_rd_if
   import fifo_pkg::*;
();

   // read strobe from the consumer
   logic    re;
   // look-ahead word sitting at the read pointer
   data_t   head;
   // registered empty flag
   logic    empty;
   // words currently held
   dcount_t dcount;

   // FIFO drives head and status, takes the strobe
   modport fifo_side (
      input  re,
      output head,
      output empty,
      output dcount
   );

   // merger side, mirror of the FIFO
   modport merge_side (
      output re,
      input  head,
      input  empty,
      input  dcount
   );

endinterface: fifo_rd_if

// ==== hdl/sync_fifo_ram.sv ====
// synchronous FIFO on dual-ported distributed RAM
// look-ahead head, registered empty flag, occupancy count and full from its top bit
// writes while full and reads while empty are masked

`timescale 1ns/1ps
`include "merge_config.svh"

module sync_fifo_ram
   import fifo_pkg::*;
#(
   parameter int DWIDTH = `MERGE_DWIDTH,
   parameter int AWIDTH = `MERGE_AWIDTH
)(
   input  logic         clk,
   input  logic         arst_n,

   // write side, straight from the producer
   input  data_t        din,
   input  logic         we,

   // read side bundle towards the merger
   fifo_rd_if.fifo_side rd,

   // high when all 2**AWIDTH words are used
   output logic         full
);

   localparam int DEPTH = 2**AWIDTH;

   // pointers wrap naturally at DEPTH
   logic [AWIDTH-1:0] wr_ptr;
   logic [AWIDTH-1:0] rd_ptr;

   // occupancy, one bit wider than the pointers
   logic [AWIDTH:0]   count;
   logic              empty_q;

   // strobes after overflow and underflow masking
   logic              we_ok;
   logic              re_ok;

   // storage, read asynchronously so it maps onto distributed RAM
   logic [DWIDTH-1:0] mem [DEPTH];

   // ----------------------------------------------------------
   // flags and strobe masking
   // ----------------------------------------------------------

   // top count bit is set only at DEPTH words
   assign full  = count[AWIDTH];

   // a write into a full FIFO is dropped
   assign we_ok = we & ~full;
   // a read of an empty FIFO is ignored
   assign re_ok = rd.re & ~empty_q;

   // ----------------------------------------------------------
   // pointers, count and empty
   // ----------------------------------------------------------

   always_ff @(posedge clk) begin
      if (!arst_n) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         empty_q <= 1'b1;
      end else begin
         if (we_ok) begin
            wr_ptr <= wr_ptr + AWIDTH'(1);
         end
         if (re_ok) begin
            rd_ptr <= rd_ptr + AWIDTH'(1);
         end

         case ({we_ok, re_ok})
            // read alone
            // empty once the last word leaves, i.e. count was one
            2'b01: begin
               count   <= count - (AWIDTH+1)'(1);
               empty_q <= ~|count[AWIDTH:1];
            end
            // write alone, never empty afterwards
            2'b10: begin
               count   <= count + (AWIDTH+1)'(1);
               empty_q <= 1'b0;
            end
            // idle, or write and read together
            default: begin
            end
         endcase
      end
   end

   // ----------------------------------------------------------
   // storage
   // ----------------------------------------------------------

   // write port
   // same location may be written while it is read as head
   always_ff @(posedge clk) begin
      if (we_ok) begin
         mem[wr_ptr] <= DWIDTH'(din);
      end
   end

   // look-ahead head, combinational at the read pointer
   assign rd.head   = data_t'(mem[rd_ptr]);

   // status towards the merger
   assign rd.empty  = empty_q;
   assign rd.dcount = dcount_t'(count);

endmodule: sync_fifo_ram

// ==== hdl/rr_merge.sv ====
// round-robin merger
// drains two FIFO look-ahead heads into one output stream tagged by channel
// one word per cycle while out_en is high

`timescale 1ns/1ps

module rr_merge
   import fifo_pkg::*;
   import merge_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n,

   // read sides of the two source FIFOs
   fifo_rd_if.merge_side src_a,
   fifo_rd_if.merge_side src_b,

   // downstream enable level
   input  logic          out_en,

   // merged output stream
   output logic          out_valid,
   output chan_t         out_chan,
   output data_t         out_data
);

   // source has a word on its head
   logic       a_avail;
   logic       b_avail;

   // a read happens this cycle
   logic       grant;
   // channel picked this cycle
   chan_t      sel;
   // head of the picked channel
   data_t      head_sel;

   // tie-break state
   arb_state_t prio;

   // ----------------------------------------------------------
   // grant selection
   // ----------------------------------------------------------

   assign a_avail = ~src_a.empty;
   assign b_avail = ~src_b.empty;

   // only issue a strobe when the output may move
   assign grant   = out_en & (a_avail | b_avail);

   // single source wins alone
   // both present means the priority state decides
   always_comb begin
      case ({a_avail, b_avail})
         2'b11:   sel = (prio == PRIO_A) ? CHAN_A : CHAN_B;
         2'b10:   sel = CHAN_A;
         // 2'b01 and the unused idle case
         default: sel = CHAN_B;
      endcase
   end

   // one strobe at most, never to an empty FIFO
   assign src_a.re = grant & (sel == CHAN_A);
   assign src_b.re = grant & (sel == CHAN_B);

   assign head_sel = (sel == CHAN_A) ? src_a.head : src_b.head;

   // ----------------------------------------------------------
   // priority state
   // ----------------------------------------------------------

   // after every grant the other channel is favoured
   always_ff @(posedge clk) begin
      if (!arst_n) begin
         prio <= PRIO_A;
      end else if (grant) begin
         prio <= (sel == CHAN_A) ? PRIO_B : PRIO_A;
      end
   end

   // ----------------------------------------------------------
   // output register
   // ----------------------------------------------------------

   // one-cycle pulse per granted word
   always_ff @(posedge clk) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= grant;
      end
   end

   // word and tag captured at the read edge
   always_ff @(posedge clk) begin
      if (grant) begin
         out_chan <= sel;
         out_data <= head_sel;
      end
   end

endmodule: rr_merge

// ==== hdl/two_chan_merge_top.sv ====
// two-channel merge subsystem
// two write-side FIFOs drained by a round-robin merger into one tagged stream

`timescale 1ns/1ps

module two_chan_merge_top
   import fifo_pkg::*;
   import merge_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n,

   // channel A writer
   input  data_t   a_data,
   input  logic    a_we,
   output logic    a_full,
   output dcount_t a_dcount,

   // channel B writer
   input  data_t   b_data,
   input  logic    b_we,
   output logic    b_full,
   output dcount_t b_dcount,

   // merged output
   input  logic    out_en,
   output logic    out_valid,
   output chan_t   out_chan,
   output data_t   out_data
);

   // read-side bundles, one per channel
   fifo_rd_if rd_a ();
   fifo_rd_if rd_b ();

   // ----------------------------------------------------------
   // channel FIFOs
   // ----------------------------------------------------------

   sync_fifo_ram i_fifo_a (
      .clk    (clk),
      .arst_n (arst_n),
      .din    (a_data),
      .we     (a_we),
      .rd     (rd_a.fifo_side),
      .full   (a_full)
   );

   sync_fifo_ram i_fifo_b (
      .clk    (clk),
      .arst_n (arst_n),
      .din    (b_data),
      .we     (b_we),
      .rd     (rd_b.fifo_side),
      .full   (b_full)
   );

   // occupancy goes straight out for monitoring
   assign a_dcount = rd_a.dcount;
   assign b_dcount = rd_b.dcount;

   // ----------------------------------------------------------
   // merger
   // ----------------------------------------------------------

   rr_merge i_merge (
      .clk       (clk),
      .arst_n    (arst_n),
      .src_a     (rd_a.merge_side),
      .src_b     (rd_b.merge_side),
      .out_en    (out_en),
      .out_valid (out_valid),
      .out_chan  (out_chan),
      .out_data  (out_data)
   );

endmodule: two_chan_merge_top

// ==== testbench/tb_clkgen.sv ====
// testbench clock and reset source
// free-running clock, reset held low for the first rising edges

`timescale 1ns/1ps

module tb_clkgen #(
   parameter int PERIOD_NS  = 4,
   parameter int RST_CYCLES = 5
)(
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // released on a rising edge so the DUT sees a clean first cycle
   initial begin
      arst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
   end

endmodule: tb_clkgen

// ==== testbench/tb_two_chan_merge.sv ====
// testbench for the two-channel merge subsystem
// queue model of both FIFOs and the round-robin merger checked every cycle

`timescale 1ns/1ps
`include "merge_config.svh"

module tb_two_chan_merge
   import fifo_pkg::*;
   import merge_pkg::*;
();

   localparam int CLK_PERIOD   = 4;
   localparam int DEPTH        = 2**`MERGE_AWIDTH;
   localparam int N_RAND       = 200;
   // writes summed over alternation, latency, overflow and random traffic
   localparam int TOTAL_WRITES = 8 + 5 + 1 + 20 + 2 * N_RAND;
   localparam int TIMEOUT_NS   = (TOTAL_WRITES * 4 + 200) * CLK_PERIOD;

   logic    clk;
   logic    arst_n;
   data_t   a_data;
   logic    a_we;
   data_t   b_data;
   logic    b_we;
   logic    out_en;
   logic    a_full;
   logic    b_full;
   dcount_t a_dcount;
   dcount_t b_dcount;
   logic    out_valid;
   chan_t   out_chan;
   data_t   out_data;

   // model FIFO contents with the oldest word first
   data_t      qa[$];
   data_t      qb[$];
   // granted words waiting for their out_valid cycle
   chan_t      exp_chan_q[$];
   data_t      exp_data_q[$];
   arb_state_t m_prio = PRIO_A;

   int     n_out = 0;
   integer seed;

   tb_clkgen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(5)) i_clkgen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   two_chan_merge_top i_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .a_data    (a_data),
      .a_we      (a_we),
      .a_full    (a_full),
      .a_dcount  (a_dcount),
      .b_data    (b_data),
      .b_we      (b_we),
      .b_full    (b_full),
      .b_dcount  (b_dcount),
      .out_en    (out_en),
      .out_valid (out_valid),
      .out_chan  (out_chan),
      .out_data  (out_data)
   );

   // ------------------------------------------------------------
   // error reporting and compare tasks
   // ------------------------------------------------------------

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_chan(input string name, input chan_t act, input chan_t exp);
      if (act !== exp) begin
         fail_run($sformatf("** Error at %0t ns: %s expected %s, got %s",
                            $time, name, exp.name(), act.name()));
      end
   endtask

   task automatic check_data(input string name, input data_t act, input data_t exp);
      if (act !== exp) begin
         fail_run($sformatf("** Error at %0t ns: %s expected 0x%04h, got 0x%04h",
                            $time, name, exp, act));
      end
   endtask

   task automatic check_count(input string name, input dcount_t act, input dcount_t exp);
      if (act !== exp) begin
         fail_run($sformatf("** Error at %0t ns: %s expected %0d, got %0d",
                            $time, name, exp, act));
      end
   endtask

   task automatic check_flag(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         fail_run($sformatf("** Error at %0t ns: %s expected %b, got %b",
                            $time, name, exp, act));
      end
   endtask

   // ------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------

   // the only available channel wins and a tie goes by the priority state
   function automatic chan_t next_grant(input bit av_a, input bit av_b,
                                        input arb_state_t prio);
      if (av_a && av_b) begin
         return (prio == PRIO_A) ? CHAN_A : CHAN_B;
      end else if (av_a) begin
         return CHAN_A;
      end
      return CHAN_B;
   endfunction

   // advance the model by the next rising edge with the inputs it will sample
   task automatic model_step();
      bit    acc_a;
      bit    acc_b;
      bit    av_a;
      bit    av_b;
      chan_t ch;
      if (!arst_n) begin
         qa.delete();
         qb.delete();
         exp_chan_q.delete();
         exp_data_q.delete();
         m_prio = PRIO_A;
      end else begin
         // full is judged on the count before the edge
         acc_a = a_we && (qa.size() < DEPTH);
         acc_b = b_we && (qb.size() < DEPTH);
         // a word written last edge is already visible here
         av_a  = qa.size() != 0;
         av_b  = qb.size() != 0;
         if (out_en && (av_a || av_b)) begin
            ch = next_grant(av_a, av_b, m_prio);
            exp_chan_q.push_back(ch);
            if (ch == CHAN_A) begin
               exp_data_q.push_back(qa.pop_front());
            end else begin
               exp_data_q.push_back(qb.pop_front());
            end
            m_prio = (ch == CHAN_A) ? PRIO_B : PRIO_A;
         end
         if (acc_a) begin
            qa.push_back(a_data);
         end
         if (acc_b) begin
            qb.push_back(b_data);
         end
      end
   endtask

   // outputs are compared mid-cycle and then the model takes the next edge
   initial begin : compare_proc
      @(posedge clk);
      forever begin
         @(negedge clk);
         check_count("a_dcount", a_dcount, dcount_t'(qa.size()));
         check_count("b_dcount", b_dcount, dcount_t'(qb.size()));
         check_flag("a_full", a_full, qa.size() == DEPTH);
         check_flag("b_full", b_full, qb.size() == DEPTH);
         check_flag("out_valid", out_valid, exp_chan_q.size() != 0);
         if (out_valid) begin
            check_chan("out_chan", out_chan, exp_chan_q.pop_front());
            check_data("out_data", out_data, exp_data_q.pop_front());
            n_out++;
         end
         model_step();
      end
   end

   initial begin : watchdog
      #(TIMEOUT_NS);
      $display("timeout: the merge run did not finish within %0d ns", TIMEOUT_NS);
      $display("TB FAILED");
      $fatal(1, "watchdog expired");
   end

   // ------------------------------------------------------------
   // stimulus phases
   // ------------------------------------------------------------

   task automatic wait_reset_done();
      @(posedge clk);
      while (!arst_n) @(posedge clk);
   endtask

   // both FIFOs empty and no word left on the output
   task automatic wait_drained();
      @(negedge clk);
      while (a_dcount != 0 || b_dcount != 0 || out_valid) @(negedge clk);
   endtask

   // expects one unbroken run of out_valid of the given length
   task automatic check_burst(input int n);
      int run;
      run = 0;
      @(negedge clk);
      while (!out_valid) @(negedge clk);
      while (out_valid) begin
         run++;
         @(negedge clk);
      end
      if (run != n) begin
         fail_run($sformatf("output burst broke up after %0d of %0d words", run, n));
      end
   endtask

   // pre-fill A with 8 and B with 5 words and then release the output
   task automatic fill_and_alternate();
      @(posedge clk);
      out_en <= 1'b0;
      for (int i = 0; i < 8; i++) begin
         @(posedge clk);
         a_we   <= 1'b1;
         a_data <= data_t'($random(seed));
         b_we   <= (i < 5);
         b_data <= data_t'($random(seed));
      end
      @(posedge clk);
      a_we   <= 1'b0;
      b_we   <= 1'b0;
      out_en <= 1'b1;
      check_burst(13);
   endtask

   // one word into an idle subsystem shows out_valid exactly two edges later
   task automatic single_word_latency();
      @(posedge clk);
      out_en <= 1'b1;
      a_we   <= 1'b1;
      a_data <= data_t'($random(seed));
      @(posedge clk);
      // the write is taken at this edge
      a_we <= 1'b0;
      @(negedge clk);
      check_flag("out_valid", out_valid, 1'b0);
      @(negedge clk);
      check_flag("out_valid", out_valid, 1'b1);
      @(negedge clk);
      check_flag("out_valid", out_valid, 1'b0);
   endtask

   // 20 writes into A while the output is held lose the last 4
   task automatic overflow_then_drain();
      int n_before;
      @(posedge clk);
      out_en <= 1'b0;
      for (int i = 0; i < 20; i++) begin
         @(posedge clk);
         a_we   <= 1'b1;
         a_data <= data_t'($random(seed));
      end
      @(posedge clk);
      a_we <= 1'b0;
      @(negedge clk);
      check_count("a_dcount", a_dcount, dcount_t'(DEPTH));
      check_flag("a_full", a_full, 1'b1);
      n_before = n_out;
      @(posedge clk);
      out_en <= 1'b1;
      wait_drained();
      if (n_out - n_before != DEPTH) begin
         fail_run($sformatf("channel A gave %0d words after overflow, expected %0d",
                            n_out - n_before, DEPTH));
      end
   endtask

   // random writes on both channels with the output enabled
   task automatic random_traffic();
      @(posedge clk);
      out_en <= 1'b1;
      for (int i = 0; i < N_RAND; i++) begin
         @(posedge clk);
         a_we   <= ($random(seed) % 2) != 0;
         a_data <= data_t'($random(seed));
         b_we   <= ($random(seed) % 2) != 0;
         b_data <= data_t'($random(seed));
      end
      @(posedge clk);
      a_we <= 1'b0;
      b_we <= 1'b0;
      wait_drained();
   endtask

   initial begin : stimulus
      seed   = 32'h2ac6;
      a_data = '0;
      a_we   = 1'b0;
      b_data = '0;
      b_we   = 1'b0;
      out_en = 1'b0;

      wait_reset_done();
      // alternation runs first while the priority still favours A
      fill_and_alternate();
      wait_drained();
      single_word_latency();
      wait_drained();
      overflow_then_drain();
      random_traffic();

      repeat (2) @(posedge clk);
      $display("TB PASSED");
      $finish;
   end

endmodule: tb_two_chan_merge

// ==== files.f ====
+incdir+hdl
hdl/fifo_pkg.sv
hdl/merge_pkg.sv
hdl/fifo_rd_if.sv
hdl/sync_fifo_ram.sv
hdl/rr_merge.sv
hdl/two_chan_merge_top.sv
testbench/tb_clkgen.sv
testbench/tb_two_chan_merge.sv

// ==== Bender.yml ====
package:
  name: two_chan_merge

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fifo_pkg.sv
      - hdl/merge_pkg.sv
      - hdl/fifo_rd_if.sv
      - hdl/sync_fifo_ram.sv
      - hdl/rr_merge.sv
      - hdl/two_chan_merge_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/tb_clkgen.sv
      - testbench/tb_two_chan_merge.sv
